/* sim.f */
logic/exu_pkg.sv
logic/csr_pkg.sv
logic/alu.sv
logic/booth_mul.sv
logic/radix2_div.sv
logic/csr_file.sv
logic/exu.sv
verification/exu_asserts.sv
verification/exu_tb.sv

/* Makefile */
TOP := exu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* verification/exu_tb.sv */
`timescale 1ns/100ps

module exu_tb;
	import exu_pkg::*;
	import csr_pkg::*;

	// tests take about 12k cycles with multiplies and divides dominating
	localparam int MAX_CYCLES = 20000;
	localparam xlen_t MIN_NEG = 64'h8000_0000_0000_0000;
	localparam xlen_t MAX_POS = 64'h7fff_ffff_ffff_ffff;
	localparam xlen_t ONES    = 64'hffff_ffff_ffff_ffff;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        in_valid;
	logic        in_ready;
	logic        out_valid;
	logic        out_ready;
	exu_op_t     op;
	xlen_t       op1;
	xlen_t       op2;
	imm_t        imm;
	xlen_t       pc;
	xlen_t       result;
	logic        jump_valid;
	xlen_t       jump_pc;
	// mscratch, mtvec, mepc, mcause
	xlen_t       csr_mirror [4];
	int unsigned cycle_count = 0;

	exu uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.op         (op),
		.op1        (op1),
		.op2        (op2),
		.imm        (imm),
		.pc         (pc),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.result     (result),
		.jump_valid (jump_valid),
		.jump_pc    (jump_pc)
	);

	bind exu exu_asserts u_asserts (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.result     (result),
		.jump_valid (jump_valid),
		.jump_pc    (jump_pc)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the DUT stopped answering after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic xlen_t rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic xlen_t sext32(logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	function automatic xlen_t alu_model(exu_op_t o, xlen_t a, xlen_t b);
		logic [31:0] aw;
		logic [31:0] bw;
		aw = a[31:0];
		bw = b[31:0];
		case (o)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			// signs differ means the negative one is smaller
			OP_SLT:  return (a[63] != b[63]) ? 64'(a[63]) : 64'(a < b);
			OP_SLTU: return 64'(a < b);
			OP_XOR:  return a ^ b;
			OP_OR:   return a | b;
			OP_AND:  return a & b;
			OP_SLL:  return a << b[5:0];
			OP_SRL:  return a >> b[5:0];
			OP_SRA:  return a[63] ? ~(~a >> b[5:0]) : a >> b[5:0];
			OP_ADDW: return sext32(aw + bw);
			OP_SUBW: return sext32(aw - bw);
			OP_SLLW: return sext32(aw << b[4:0]);
			OP_SRLW: return sext32(aw >> b[4:0]);
			OP_SRAW: return sext32(aw[31] ? ~(~aw >> b[4:0]) : aw >> b[4:0]);
			default: return '0;
		endcase
	endfunction

	function automatic xlen_t mul_model(exu_op_t o, xlen_t a, xlen_t b);
		logic         sa;
		logic         sb;
		logic [127:0] p;
		sa = (o != OP_MULHU);
		sb = (o != OP_MULHU) && (o != OP_MULHSU);
		p  = {{64{sa & a[63]}}, a} * {{64{sb & b[63]}}, b};
		case (o)
			OP_MUL:  return p[63:0];
			OP_MULW: return sext32(p[31:0]);
			default: return p[127:64];
		endcase
	endfunction

	function automatic xlen_t div_model(exu_op_t o, xlen_t a, xlen_t b);
		logic  sgn;
		logic  word;
		xlen_t x;
		xlen_t y;
		xlen_t q;
		xlen_t r;
		sgn  = o inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
		word = o inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
		x    = word ? (sgn ? sext32(a[31:0]) : {32'd0, a[31:0]}) : a;
		y    = word ? (sgn ? sext32(b[31:0]) : {32'd0, b[31:0]}) : b;
		if (y == '0) begin
			q = ONES;
			r = x;
		end else if (sgn && x == MIN_NEG && y == ONES) begin
			q = x;
			r = '0;
		end else if (sgn) begin
			q = $signed(x) / $signed(y);
			r = $signed(x) % $signed(y);
		end else begin
			q = x / y;
			r = x % y;
		end
		if (o inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW})
			q = r;
		return word ? sext32(q[31:0]) : q;
	endfunction

	function automatic int csr_index(csr_addr_t addr);
		case (addr)
			CSR_MSCRATCH: return 0;
			CSR_MTVEC:    return 1;
			CSR_MEPC:     return 2;
			CSR_MCAUSE:   return 3;
			default:      return -1;
		endcase
	endfunction

	task automatic check(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			$display("TEST FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// one operation through both handshakes with a stall of hold cycles
	task automatic run_op(input exu_op_t o, input xlen_t a, input xlen_t b, input imm_t im,
			input xlen_t p, input xlen_t exp_res, input logic exp_jump, input xlen_t exp_jpc,
			input int hold);
		string tag;
		tag = o.name();
		op        <= o;
		op1       <= a;
		op2       <= b;
		imm       <= im;
		pc        <= p;
		in_valid  <= 1'b1;
		out_ready <= (hold == 0);
		do @(posedge clk); while (!in_ready);
		in_valid <= 1'b0;
		// scramble the operands once they are captured
		op1 <= rand64();
		op2 <= rand64();
		pc  <= rand64();
		do @(posedge clk); while (!out_valid);
		for (int i = 0; i < hold; i++) begin
			check({tag, " in_ready"}, 64'(in_ready), 64'd0);
			check({tag, " result"}, result, exp_res);
			if (i == hold - 1)
				out_ready <= 1'b1;
			@(posedge clk);
		end
		if (hold > 0)
			check({tag, " out_valid"}, 64'(out_valid), 64'd1);
		check({tag, " result"}, result, exp_res);
		check({tag, " jump_valid"}, 64'(jump_valid), 64'(exp_jump));
		if (exp_jump)
			check({tag, " jump_pc"}, jump_pc, exp_jpc);
	endtask

	task automatic csr_access(input exu_op_t o, input csr_addr_t addr, input xlen_t src);
		int    idx;
		xlen_t old;
		idx = csr_index(addr);
		old = (idx < 0) ? '0 : csr_mirror[idx[1:0]];
		run_op(o, src, rand64(), addr, rand64(), old, 1'b0, '0, 0);
		if (idx >= 0) begin
			case (o)
				OP_CSRRW: csr_mirror[idx[1:0]] = src;
				OP_CSRRS: csr_mirror[idx[1:0]] = old | src;
				OP_CSRRC: csr_mirror[idx[1:0]] = old & ~src;
				default: ;
			endcase
		end
	endtask

	task automatic alu_ops();
		xlen_t   edges [5];
		int      shifts [4];
		xlen_t   a;
		xlen_t   b;
		exu_op_t o;
		edges  = '{64'd0, ONES, MIN_NEG, 64'd1, MAX_POS};
		shifts = '{0, 31, 32, 63};
		for (int k = int'(OP_ADD); k <= int'(OP_SRAW); k++) begin
			o = exu_op_t'(k);
			foreach (edges[i])
				foreach (edges[j])
					run_op(o, edges[i], edges[j], '0, '0, alu_model(o, edges[i], edges[j]),
						1'b0, '0, 0);
			foreach (shifts[s]) begin
				a = rand64();
				b = xlen_t'(shifts[s]);
				run_op(o, a, b, '0, '0, alu_model(o, a, b), 1'b0, '0, 0);
			end
			repeat (8) begin
				a = rand64();
				b = rand64();
				run_op(o, a, b, '0, '0, alu_model(o, a, b), 1'b0, '0, 0);
			end
		end
	endtask

	task automatic multiply_ops();
		xlen_t   vals [4];
		xlen_t   a;
		xlen_t   b;
		exu_op_t o;
		vals = '{MIN_NEG, ONES, MAX_POS, 64'h0000_0000_8000_0000};
		for (int k = int'(OP_MUL); k <= int'(OP_MULW); k++) begin
			o = exu_op_t'(k);
			foreach (vals[i])
				foreach (vals[j])
					run_op(o, vals[i], vals[j], '0, '0, mul_model(o, vals[i], vals[j]),
						1'b0, '0, 0);
			repeat (6) begin
				a = rand64();
				b = rand64();
				run_op(o, a, b, '0, '0, mul_model(o, a, b), 1'b0, '0, 0);
			end
		end
	endtask

	task automatic divide_ops();
		xlen_t   a;
		xlen_t   b;
		exu_op_t o;
		for (int k = int'(OP_DIV); k <= int'(OP_REMUW); k++) begin
			o = exu_op_t'(k);
			repeat (6) begin
				a = rand64();
				b = rand64() >> ($urandom % 64);
				run_op(o, a, b, '0, '0, div_model(o, a, b), 1'b0, '0, 0);
			end
			a = rand64();
			run_op(o, a, 64'd0, '0, '0, div_model(o, a, 64'd0), 1'b0, '0, 0);
			// zero only in the low word
			b = 64'hffff_ffff_0000_0000;
			run_op(o, a, b, '0, '0, div_model(o, a, b), 1'b0, '0, 0);
			run_op(o, MIN_NEG, ONES, '0, '0, div_model(o, MIN_NEG, ONES), 1'b0, '0, 0);
			a = 64'h0000_0000_8000_0000;
			run_op(o, a, ONES, '0, '0, div_model(o, a, ONES), 1'b0, '0, 0);
		end
	endtask

	task automatic csr_ops();
		csr_addr_t addrs [5];
		addrs = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, 12'h7c0};
		foreach (addrs[i]) begin
			csr_access(OP_CSRRW, addrs[i], rand64());
			csr_access(OP_CSRRS, addrs[i], rand64());
			csr_access(OP_CSRRC, addrs[i], rand64());
			csr_access(OP_CSRRS, addrs[i], 64'd0);
		end
	endtask

	task automatic trap_and_return();
		xlen_t vec;
		xlen_t trap_pc;
		csr_access(OP_CSRRW, CSR_MTVEC, rand64());
		vec     = {csr_mirror[1][63:2], 2'b00};
		trap_pc = rand64() & ~64'h3;
		run_op(OP_ECALL, rand64(), rand64(), '0, trap_pc, '0, 1'b1, vec, 0);
		csr_mirror[2] = trap_pc;
		csr_mirror[3] = 64'd11;
		csr_access(OP_CSRRS, CSR_MEPC, 64'd0);
		csr_access(OP_CSRRS, CSR_MCAUSE, 64'd0);
		run_op(OP_MRET, rand64(), rand64(), '0, rand64(), '0, 1'b1, trap_pc, 0);
	endtask

	task automatic stalled_outputs();
		xlen_t a;
		xlen_t b;
		repeat (3) begin
			a = rand64();
			b = rand64();
			run_op(OP_XOR, a, b, '0, '0, alu_model(OP_XOR, a, b), 1'b0, '0,
				1 + int'($urandom % 8));
			b = b >> 20;
			run_op(OP_DIVU, a, b, '0, '0, div_model(OP_DIVU, a, b), 1'b0, '0,
				1 + int'($urandom % 8));
		end
	endtask

	initial begin
		void'($urandom(30405));
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		op        = OP_ADD;
		op1       = '0;
		op2       = '0;
		imm       = '0;
		pc        = '0;
		foreach (csr_mirror[i])
			csr_mirror[i] = '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		check("in_ready", 64'(in_ready), 64'd1);
		check("out_valid", 64'(out_valid), 64'd0);
		check("jump_valid", 64'(jump_valid), 64'd0);
		alu_ops();
		multiply_ops();
		divide_ops();
		csr_ops();
		trap_and_return();
		stalled_outputs();
		if (uut.u_asserts.fail_count != 0) begin
			$display("%0d handshake assertions failed", uut.u_asserts.fail_count);
			$display("TEST FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

/* verification/exu_asserts.sv */
`timescale 1ns/100ps

module exu_asserts (
	input logic           clk,
	input logic           arst_n,
	input logic           in_valid,
	input logic           in_ready,
	input logic           out_valid,
	input logic           out_ready,
	input exu_pkg::xlen_t result,
	input logic           jump_valid,
	input exu_pkg::xlen_t jump_pc
);
	int unsigned fail_count = 0;
	logic        accepted;
	logic        in_flight;

	// set by the first operation taken after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			accepted <= 1'b0;
		else if (in_valid && in_ready)
			accepted <= 1'b1;
	end

	// high from acceptance until the result leaves
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			in_flight <= 1'b0;
		else if (in_valid && in_ready)
			in_flight <= 1'b1;
		else if (out_valid && out_ready)
			in_flight <= 1'b0;
	end

	hold_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(result) && $stable(jump_valid)
			&& $stable(jump_pc))
	else begin
		fail_count++;
		$error("output changed while out_ready was low");
	end

	one_op_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
		in_flight |-> !in_ready)
	else begin
		fail_count++;
		$error("in_ready rose before the previous result left");
	end

	no_result_before_accept: assert property (@(posedge clk) disable iff (!arst_n)
		!accepted |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid rose before any operation was accepted");
	end

endmodule

/* logic/exu.sv */
`timescale 1ns/100ps

module exu (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  exu_pkg::exu_op_t  op,
	input  exu_pkg::xlen_t    op1,
	input  exu_pkg::xlen_t    op2,
	input  exu_pkg::imm_t     imm,
	input  exu_pkg::xlen_t    pc,
	output logic              out_valid,
	input  logic              out_ready,
	output exu_pkg::xlen_t    result,
	output logic              jump_valid,
	output exu_pkg::xlen_t    jump_pc
);
	import exu_pkg::*;
	import csr_pkg::*;

	exu_state_t state;
	exu_op_t    op_q;
	xlen_t      op1_q;
	xlen_t      op2_q;
	logic       accept;
	logic       redirect;
	logic       mul_start;
	logic       div_start;
	logic       mul_busy;
	logic       mul_done;
	logic       div_busy;
	logic       div_done;
	logic       word_op;
	logic       ext_signed;
	logic       div_signed;
	logic       mul_a_signed;
	logic       mul_b_signed;
	xlen_t      unit_a;
	xlen_t      unit_b;
	xlen_t      prod_hi;
	xlen_t      prod_lo;
	xlen_t      quot;
	xlen_t      rem;
	xlen_t      mul_sel;
	xlen_t      div_sel;
	xlen_t      alu_y;
	xlen_t      csr_rdata;
	xlen_t      csr_redirect;
	xlen_t      sys_result;
	csr_addr_t  csr_addr;

	function automatic xlen_t ext_word(xlen_t v, logic s);
		return s ? {{32{v[31]}}, v[31:0]} : {32'd0, v[31:0]};
	endfunction

	assign in_ready  = (state == ST_IDLE) && !mul_busy && !div_busy;
	assign out_valid = (state == ST_DONE);
	assign accept    = in_valid && in_ready;
	assign redirect  = op inside {OP_ECALL, OP_MRET};

	// single cycle units work on the operands of the accept cycle
	alu u_alu (
		.op (op),
		.a  (op1),
		.b  (op2),
		.y  (alu_y)
	);

	assign csr_addr = csr_addr_t'(imm);

	csr_file u_csr (
		.clk         (clk),
		.arst_n      (arst_n),
		.wr_en       (accept),
		.op          (op),
		.addr        (csr_addr),
		.src         (op1),
		.pc          (pc),
		.rdata       (csr_rdata),
		.redirect_pc (csr_redirect)
	);

	assign sys_result = redirect ? '0 : csr_rdata;

	// operand preparation for the iterative units
	assign word_op      = op_q inside {OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
	assign div_signed   = op_q inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
	assign mul_a_signed = op_q inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULW};
	assign mul_b_signed = op_q inside {OP_MUL, OP_MULH, OP_MULW};
	assign ext_signed   = mul_a_signed | div_signed;
	assign unit_a       = word_op ? ext_word(op1_q, ext_signed) : op1_q;
	assign unit_b       = word_op ? ext_word(op2_q, ext_signed) : op2_q;

	booth_mul #(
		.WIDTH (XLEN)
	) u_mul (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (mul_start),
		.a_signed (mul_a_signed),
		.b_signed (mul_b_signed),
		.a        (unit_a),
		.b        (unit_b),
		.busy     (mul_busy),
		.done     (mul_done),
		.prod_hi  (prod_hi),
		.prod_lo  (prod_lo)
	);

	radix2_div #(
		.WIDTH (XLEN)
	) u_div (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (div_start),
		.is_signed (div_signed),
		.dividend  (unit_a),
		.divisor   (unit_b),
		.busy      (div_busy),
		.done      (div_done),
		.quot      (quot),
		.rem       (rem)
	);

	always_comb begin
		case (op_q)
			OP_MUL:  mul_sel = prod_lo;
			OP_MULW: mul_sel = ext_word(prod_lo, 1'b1);
			default: mul_sel = prod_hi;
		endcase
	end

	always_comb begin
		div_sel = (op_q inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW}) ? rem : quot;
		if (word_op)
			div_sel = ext_word(div_sel, 1'b1);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			mul_start  <= 1'b0;
			div_start  <= 1'b0;
			jump_valid <= 1'b0;
		end else begin
			// one cycle start pulse after capture
			mul_start <= accept && is_mul_op(op);
			div_start <= accept && is_div_op(op);
			case (state)
				ST_IDLE:
					if (accept) begin
						jump_valid <= redirect;
						if (is_mul_op(op))
							state <= ST_MUL;
						else if (is_div_op(op))
							state <= ST_DIV;
						else
							state <= ST_DONE;
					end
				ST_MUL:
					if (mul_done)
						state <= ST_DONE;
				ST_DIV:
					if (div_done)
						state <= ST_DONE;
				ST_DONE:
					if (out_ready) begin
						state      <= ST_IDLE;
						jump_valid <= 1'b0;
					end
			endcase
		end
	end

	// result register, held until the output handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q    <= op;
			op1_q   <= op1;
			op2_q   <= op2;
			result  <= is_sys_op(op) ? sys_result : alu_y;
			jump_pc <= csr_redirect;
		end else if (state == ST_MUL && mul_done) begin
			result <= mul_sel;
		end else if (state == ST_DIV && div_done) begin
			result <= div_sel;
		end
	end

endmodule

/* logic/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               wr_en,
	input  exu_pkg::exu_op_t   op,
	input  csr_pkg::csr_addr_t addr,
	input  exu_pkg::xlen_t     src,
	input  exu_pkg::xlen_t     pc,
	output exu_pkg::xlen_t     rdata,
	output exu_pkg::xlen_t     redirect_pc
);
	import exu_pkg::*;
	import csr_pkg::*;

	xlen_t mscratch;
	xlen_t mtvec;
	xlen_t mepc;
	xlen_t mcause;
	xlen_t wdata;
	logic  addr_hit;
	logic  csr_wr;

	always_comb begin
		addr_hit = 1'b1;
		case (addr)
			CSR_MSCRATCH: rdata = mscratch;
			CSR_MTVEC:    rdata = mtvec;
			CSR_MEPC:     rdata = mepc;
			CSR_MCAUSE:   rdata = mcause;
			default: begin
				rdata    = '0;
				addr_hit = 1'b0;
			end
		endcase
	end

	// read-modify-write on the old value
	always_comb begin
		case (op)
			OP_CSRRW: wdata = src;
			OP_CSRRS: wdata = rdata | src;
			OP_CSRRC: wdata = rdata & ~src;
			default:  wdata = rdata;
		endcase
	end

	assign csr_wr = wr_en && addr_hit && (op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC});

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mscratch <= '0;
			mtvec    <= '0;
			mepc     <= '0;
			mcause   <= '0;
		end else if (csr_wr) begin
			case (addr)
				CSR_MSCRATCH: mscratch <= wdata;
				CSR_MTVEC:    mtvec    <= wdata;
				CSR_MEPC:     mepc     <= wdata;
				CSR_MCAUSE:   mcause   <= wdata;
				default: ;
			endcase
		end else if (wr_en && op == OP_ECALL) begin
			// trap entry
			mepc   <= pc;
			mcause <= CAUSE_ECALL_M;
		end
	end

	// direct mode only, mtvec mode bits ignored
	always_comb begin
		case (op)
			OP_ECALL: redirect_pc = {mtvec[XLEN-1:2], 2'b00};
			OP_MRET:  redirect_pc = mepc;
			default:  redirect_pc = '0;
		endcase
	end

endmodule

/* logic/radix2_div.sv */
`timescale 1ns/100ps

module radix2_div #(
	parameter int WIDTH = 64
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             start,
	input  logic             is_signed,
	input  logic [WIDTH-1:0] dividend,
	input  logic [WIDTH-1:0] divisor,
	output logic             busy,
	output logic             done,
	output logic [WIDTH-1:0] quot,
	output logic [WIDTH-1:0] rem
);
	localparam int CW = $clog2(WIDTH);

	logic [WIDTH-1:0] dvd_abs;
	logic [WIDTH-1:0] dvs_abs;
	logic [WIDTH-1:0] dvs_r;
	logic [WIDTH-1:0] rem_r;
	logic [WIDTH-1:0] quo_r;
	logic [WIDTH:0]   shifted;
	logic [WIDTH+1:0] trial;
	logic             q_neg;
	logic             r_neg;
	logic             div_zero;
	logic [CW-1:0]    count;
	logic             last_step;

	// magnitudes; the most negative value maps onto itself as unsigned
	assign dvd_abs = (is_signed && dividend[WIDTH-1]) ? -dividend : dividend;
	assign dvs_abs = (is_signed && divisor[WIDTH-1]) ? -divisor : divisor;

	// next dividend bit enters from the top of quo_r
	assign shifted = {rem_r, quo_r[WIDTH-1]};
	assign trial   = {1'b0, shifted} - {2'b00, dvs_r};

	assign last_step = (count == CW'(WIDTH - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= busy && last_step;
			if (start) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (last_step)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem_r    <= '0;
			quo_r    <= dvd_abs;
			dvs_r    <= dvs_abs;
			q_neg    <= is_signed & (dividend[WIDTH-1] ^ divisor[WIDTH-1]);
			r_neg    <= is_signed & dividend[WIDTH-1];
			div_zero <= (divisor == '0);
		end else if (busy) begin
			// restore on borrow, otherwise keep the difference
			if (!trial[WIDTH+1]) begin
				rem_r <= trial[WIDTH-1:0];
				quo_r <= {quo_r[WIDTH-2:0], 1'b1};
			end else begin
				rem_r <= shifted[WIDTH-1:0];
				quo_r <= {quo_r[WIDTH-2:0], 1'b0};
			end
		end
	end

	// signed overflow already yields the dividend and a zero remainder here
	assign quot = div_zero ? '1 : (q_neg ? -quo_r : quo_r);
	// zero divisor leaves |dividend| in rem_r, sign restore gives the dividend
	assign rem  = r_neg ? -rem_r : rem_r;

endmodule

/* logic/booth_mul.sv */
`timescale 1ns/100ps

module booth_mul #(
	parameter int WIDTH = 64
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             start,
	input  logic             a_signed,
	input  logic             b_signed,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic             busy,
	output logic             done,
	output logic [WIDTH-1:0] prod_hi,
	output logic [WIDTH-1:0] prod_lo
);
	// two extra bits keep unsigned operands positive in two's complement
	localparam int EW    = WIDTH + 2;
	localparam int PW    = 2 * WIDTH;
	localparam int STEPS = EW / 2;
	localparam int CW    = $clog2(STEPS);

	logic [EW-1:0] a_ext;
	logic [EW-1:0] b_ext;
	logic [PW-1:0] mcand;
	logic [EW:0]   mplier;
	logic [PW-1:0] acc;
	logic [PW-1:0] pp;
	logic [CW-1:0] count;
	logic          last_step;

	assign a_ext = {{2{a_signed & a[WIDTH-1]}}, a};
	assign b_ext = {{2{b_signed & b[WIDTH-1]}}, b};

	assign last_step = (count == CW'(STEPS - 1));

	// booth digit from the low three multiplier bits
	always_comb begin
		case (mplier[2:0])
			3'b001, 3'b010:
				pp = mcand;
			3'b011:
				pp = mcand << 1;
			3'b100:
				pp = -(mcand << 1);
			3'b101, 3'b110:
				pp = -mcand;
			default:
				pp = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= busy && last_step;
			if (start) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (last_step)
					busy <= 1'b0;
			end
		end
	end

	// accumulation wraps at 2*WIDTH bits, which is all the product needs
	always_ff @(posedge clk) begin
		if (start) begin
			mcand  <= {{(WIDTH-2){a_ext[EW-1]}}, a_ext};
			mplier <= {b_ext, 1'b0};
			acc    <= '0;
		end else if (busy) begin
			acc    <= acc + pp;
			mcand  <= mcand << 2;
			mplier <= {2'b00, mplier[EW:2]};
		end
	end

	assign prod_lo = acc[WIDTH-1:0];
	assign prod_hi = acc[PW-1:WIDTH];

endmodule

/* logic/alu.sv */
`timescale 1ns/100ps

module alu (
	input  exu_pkg::exu_op_t op,
	input  exu_pkg::xlen_t   a,
	input  exu_pkg::xlen_t   b,
	output exu_pkg::xlen_t   y
);
	import exu_pkg::*;

	xlen_t sum;
	xlen_t diff;
	logic [31:0] sllw_w;
	logic [31:0] srlw_w;
	logic [31:0] sraw_w;

	assign sum  = a + b;
	assign diff = a - b;

	// word shifts use only the low five bits of b
	assign sllw_w = a[31:0] << b[4:0];
	assign srlw_w = a[31:0] >> b[4:0];
	assign sraw_w = $signed(a[31:0]) >>> b[4:0];

	function automatic xlen_t sext32(logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	always_comb begin
		case (op)
			OP_ADD:
				y = sum;
			OP_SUB:
				y = diff;
			OP_SLT:
				y = {63'd0, $signed(a) < $signed(b)};
			OP_SLTU:
				y = {63'd0, a < b};
			OP_XOR:
				y = a ^ b;
			OP_OR:
				y = a | b;
			OP_AND:
				y = a & b;
			OP_SLL:
				y = a << b[5:0];
			OP_SRL:
				y = a >> b[5:0];
			OP_SRA:
				y = $signed(a) >>> b[5:0];
			// word forms, 32 bit result sign extended
			OP_ADDW:
				y = sext32(sum[31:0]);
			OP_SUBW:
				y = sext32(diff[31:0]);
			OP_SLLW:
				y = sext32(sllw_w);
			OP_SRLW:
				y = sext32(srlw_w);
			OP_SRAW:
				y = sext32(sraw_w);
			default:
				y = '0;
		endcase
	end

endmodule

/* logic/csr_pkg.sv */
package csr_pkg;

	typedef logic [11:0] csr_addr_t;

	// machine mode CSRs held in csr_file
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;

	// environment call from machine mode
	localparam logic [63:0] CAUSE_ECALL_M = 64'd11;

endpackage

/* logic/exu_pkg.sv */
package exu_pkg;

	localparam int XLEN = 64;

	// data word for operands, results and pc
	typedef logic [XLEN-1:0] xlen_t;

	// immediate field, also the CSR address on system ops
	typedef logic [11:0] imm_t;

	typedef enum logic [5:0] {
		OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
		OP_SLL, OP_SRL, OP_SRA,
		OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
		OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW,
		OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_ECALL, OP_MRET
	} exu_op_t;

	// execute stage control
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL,
		ST_DIV,
		ST_DONE
	} exu_state_t;

	function automatic logic is_mul_op(exu_op_t op);
		return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
	endfunction

	function automatic logic is_div_op(exu_op_t op);
		return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU,
			OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
	endfunction

	// csr access plus trap entry and return
	function automatic logic is_sys_op(exu_op_t op);
		return op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_ECALL, OP_MRET};
	endfunction

endpackage
